//--- dataTlbBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module dataTlbBuffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  mmuPkg::vpn_t        vpn,
    input  logic                read,
    input  logic                store,
    input  mmuPkg::cacheAttr_t  configK0,
    output mmuPkg::pfn_t        pfn,
    output logic                uncached,
    output mmuPkg::excCode_t    exc,
    output logic                stall,
    tlbLookupIf.requester       lookup
);
    import mmuPkg::*;

    refillState_t state;
    refillState_t stateNext;
    logic         bufValid;
    logic         bufFound;
    vpn2_t        bufVpn2;
    tlbEntry_t    bufEntry;

    logic         unmapped;
    logic         inKseg1;
    logic         access;
    logic         bufHit;
    logic         startRefill;
    logic         capture;
    pfn_t         pagePfn;
    cacheAttr_t   pageAttr;
    logic         pageDirty;
    logic         pageValid;

    assign unmapped = (vpn[19:16] >= segKseg0) && (vpn[19:16] <= segKseg1);
    assign inKseg1  = unmapped && vpn[17];   // A or B
    assign access   = read || store;
    assign bufHit   = bufValid && (bufVpn2 == vpn[19:1]);
    assign stall    = !unmapped && access && !bufHit;

    // vpn[0] picks the odd page of the pair
    assign pagePfn   = vpn[0] ? bufEntry.pfn1 : bufEntry.pfn0;
    assign pageAttr  = vpn[0] ? bufEntry.c1   : bufEntry.c0;
    assign pageDirty = vpn[0] ? bufEntry.d1   : bufEntry.d0;
    assign pageValid = vpn[0] ? bufEntry.v1   : bufEntry.v0;

    always_comb begin
        if (inKseg1) begin
            pfn      = {3'b000, vpn[16:0]};
            uncached = 1'b1;
        end else if (unmapped) begin
            pfn      = {1'b0, vpn[18:0]};
            uncached = (configK0 != cachedAttr);
        end else begin
            pfn      = pagePfn;
            uncached = (pageAttr != cachedAttr);
        end
    end

    always_comb begin
        exc = excNone;
        if (!unmapped && access && bufHit) begin
            if (!bufFound) begin
                exc = store ? excWrRefill : excRdRefill;
            end else if (!pageValid) begin
                exc = store ? excWrInvalid : excRdInvalid;
            end else if (store && !pageDirty) begin
                exc = excModified;
            end
        end
    end

    assign startRefill = (state == rfIdle) && stall;
    assign capture     = (state == rfReq) && lookup.ack;

    always_comb begin
        stateNext = state;
        case (state)
            rfIdle: begin
                if (stall) begin
                    stateNext = rfReq;
                end
            end
            rfReq: begin
                if (lookup.ack) begin
                    stateNext = rfRelease;
                end
            end
            rfRelease: begin
                if (!lookup.ack) begin
                    stateNext = rfIdle;
                end
            end
            default: stateNext = rfIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= rfIdle;
            bufValid <= 1'b0;
        end else begin
            state <= stateNext;
            if (flush || startRefill) begin
                bufValid <= 1'b0;   // a flush also drops a capture in flight
            end else if (capture) begin
                bufValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startRefill) begin
            bufVpn2 <= vpn[19:1];
        end
        if (capture) begin
            bufEntry <= lookup.entry;
            bufFound <= lookup.found;
        end
    end

    assign lookup.req  = (state == rfReq);
    assign lookup.vpn2 = bufVpn2;

    assert property (@(posedge clk) disable iff (reset) !(read && store))
        else $error("load and store requested together");

endmodule

`default_nettype wire

//--- instTlbBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module instTlbBuffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  mmuPkg::vpn_t      vpn,
    input  logic              fetchEn,
    output mmuPkg::pfn_t      pfn,
    output mmuPkg::excCode_t  exc,
    output logic              stall,
    tlbLookupIf.requester     lookup
);
    import mmuPkg::*;

    refillState_t state;
    refillState_t stateNext;
    logic         bufValid;
    logic         bufFound;
    vpn2_t        bufVpn2;
    tlbEntry_t    bufEntry;

    logic         unmapped;
    logic         bufHit;
    logic         startRefill;
    logic         capture;

    assign unmapped = (vpn[19:16] >= segKseg0) && (vpn[19:16] <= segKseg1);
    assign bufHit   = bufValid && (bufVpn2 == vpn[19:1]);
    assign stall    = !unmapped && fetchEn && !bufHit;

    always_comb begin
        if (unmapped && vpn[17]) begin
            pfn = {3'b000, vpn[16:0]};   // kseg1
        end else if (unmapped) begin
            pfn = {1'b0, vpn[18:0]};     // kseg0
        end else begin
            pfn = vpn[0] ? bufEntry.pfn1 : bufEntry.pfn0;
        end
    end

    always_comb begin
        exc = excNone;
        if (!unmapped && fetchEn && bufHit) begin
            if (!bufFound) begin
                exc = excFetchRefill;
            end else if (!(vpn[0] ? bufEntry.v1 : bufEntry.v0)) begin
                exc = excFetchInvalid;
            end
        end
    end

    assign startRefill = (state == rfIdle) && stall;
    assign capture     = (state == rfReq) && lookup.ack;

    always_comb begin
        stateNext = state;
        case (state)
            rfIdle:    stateNext = stall ? rfReq : rfIdle;
            rfReq:     stateNext = lookup.ack ? rfRelease : rfReq;
            rfRelease: stateNext = lookup.ack ? rfRelease : rfIdle;
            default:   stateNext = rfIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= rfIdle;
            bufValid <= 1'b0;
        end else begin
            state <= stateNext;
            if (flush || startRefill) begin
                bufValid <= 1'b0;
            end else if (capture) begin
                bufValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startRefill) begin
            bufVpn2 <= vpn[19:1];
        end
        if (capture) begin
            bufEntry <= lookup.entry;
            bufFound <= lookup.found;
        end
    end

    assign lookup.req  = (state == rfReq);
    assign lookup.vpn2 = bufVpn2;

endmodule

`default_nettype wire

//--- jointTlb.sv
`timescale 1ns/1ps
`default_nettype none

module jointTlb (
    input  logic               clk,
    input  logic               reset,
    input  logic               write,
    input  mmuPkg::tlbIndex_t  writeIndex,
    input  mmuPkg::tlbEntry_t  writeEntry,
    tlbLookupIf.responder      port
);
    import mmuPkg::*;

    tlbEntry_t             entries [tlbEntries];
    logic [tlbEntries-1:0] entryValid;
    logic [tlbEntries-1:0] hitVec;

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
        end else if (write) begin
            entryValid[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            entries[writeIndex] <= writeEntry;   // tlbwi
        end
    end

    always_comb begin
        for (int i = 0; i < tlbEntries; i++) begin
            hitVec[i] = entryValid[i] && (entries[i].vpn2 == port.vpn2);
        end
    end

    // walk down so the lowest matching index is the one left standing
    always_comb begin
        port.found = 1'b0;
        port.entry = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (hitVec[i]) begin
                port.found = 1'b1;
                port.entry = entries[i];
            end
        end
        port.entry.valid = port.found;
    end

    assign port.ack = port.req;   // lookup is combinational

    // software must never leave two entries mapping the same page pair
    assert property (@(posedge clk) disable iff (reset)
        port.req |-> $onehot0(hitVec))
        else $error("joint TLB holds more than one match for vpn2 %h", port.vpn2);

endmodule

`default_nettype wire

//--- mmuPkg.sv
`default_nettype none

package mmuPkg;

    typedef logic [19:0] vpn_t;        // va[31:12]
    typedef logic [19:0] pfn_t;        // pa[31:12]
    typedef logic [18:0] vpn2_t;       // va[31:13], names an even/odd page pair
    typedef logic [2:0]  cacheAttr_t;
    typedef logic [4:0]  excCode_t;
    typedef logic [3:0]  tlbIndex_t;

    typedef struct packed {
        vpn2_t      vpn2;
        pfn_t       pfn0;              // even page
        cacheAttr_t c0;
        logic       d0;
        logic       v0;
        pfn_t       pfn1;              // odd page
        cacheAttr_t c1;
        logic       d1;
        logic       v1;
        logic       valid;             // entry written at least once
    } tlbEntry_t;

    localparam int tlbEntries = 16;

    localparam cacheAttr_t cachedAttr = 3'd3;  // cacheable, noncoherent

    // unmapped window is va[31:28] in 8..B, kseg0 at the bottom, kseg1 at the top
    localparam logic [3:0] segKseg0 = 4'h8;
    localparam logic [3:0] segKseg1 = 4'hB;

    localparam excCode_t excNone         = 5'd0;
    localparam excCode_t excModified     = 5'd1;
    localparam excCode_t excRdRefill     = 5'd2;
    localparam excCode_t excWrRefill     = 5'd3;
    localparam excCode_t excRdInvalid    = 5'd4;
    localparam excCode_t excWrInvalid    = 5'd5;
    localparam excCode_t excFetchRefill  = 5'd6;
    localparam excCode_t excFetchInvalid = 5'd7;

    typedef enum logic [1:0] {
        rfIdle,
        rfReq,                         // req high, waiting for ack
        rfRelease                      // req low, waiting for ack to fall
    } refillState_t;

    typedef enum logic [1:0] {
        grantNone,
        grantData,
        grantInst
    } grant_t;

endpackage

`default_nettype wire

//--- mmuTb.sv
`timescale 1ns/1ps
`default_nettype none

module mmuTb;
    import mmuPkg::*;

    localparam int          maxCmds    = 64;
    localparam int          numFields  = 10;
    localparam logic [31:0] randomSeed = 32'h6cb3_9850;
    localparam logic [31:0] dontCare   = 32'hffff_ffff;

    logic         clk;
    logic         reset;
    vpn_t         dataVpn;
    logic         dataRead;
    logic         dataStore;
    cacheAttr_t   configK0;
    vpn_t         fetchVpn;
    logic         fetchEn;
    logic         tlbWrite;
    tlbIndex_t    tlbWriteIndex;
    tlbEntry_t    tlbWriteEntry;
    pfn_t         dataPfn;
    logic         dataUncached;
    excCode_t     dataExc;
    logic         dataStall;
    pfn_t         fetchPfn;
    excCode_t     fetchExc;
    logic         fetchStall;

    byte          cmdKind  [maxCmds];
    int           cmdLine  [maxCmds];
    logic [31:0]  cmdField [maxCmds][numFields];
    int           order    [maxCmds];   // execution order after shuffling
    int           numCmds;
    int           cycles;
    int           cycleLimit;
    logic [31:0]  randState;

    mmuTop dut0 (
        .clk           (clk),
        .reset         (reset),
        .dataVpn       (dataVpn),
        .dataRead      (dataRead),
        .dataStore     (dataStore),
        .configK0      (configK0),
        .fetchVpn      (fetchVpn),
        .fetchEn       (fetchEn),
        .tlbWrite      (tlbWrite),
        .tlbWriteIndex (tlbWriteIndex),
        .tlbWriteEntry (tlbWriteEntry),
        .dataPfn       (dataPfn),
        .dataUncached  (dataUncached),
        .dataExc       (dataExc),
        .dataStall     (dataStall),
        .fetchPfn      (fetchPfn),
        .fetchExc      (fetchExc),
        .fetchStall    (fetchStall)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            abortRun($sformatf("timeout: run still busy after %0d cycles", cycles));
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected != dontCare && expected !== actual) begin
            abortRun($sformatf("FAILED %s: expected %h, actual %h", testName, expected, actual));
        end
    endtask

    task automatic readCommands();
        int    fd;
        int    lineNo;
        string text;
        fd     = $fopen("mmuTestdata.txt", "r");
        lineNo = 0;
        if (fd == 0) begin
            abortRun("could not open mmuTestdata.txt");
        end else begin
            while ($fgets(text, fd) != 0) begin
                lineNo++;
                if (text.len() > 1 && text[0] != "#" && numCmds < maxCmds) begin
                    for (int k = 0; k < numFields; k++) begin
                        cmdField[numCmds][k] = '0;
                    end
                    void'($sscanf(text, "%c %h %h %h %h %h %h %h %h %h %h", cmdKind[numCmds],
                        cmdField[numCmds][0], cmdField[numCmds][1], cmdField[numCmds][2],
                        cmdField[numCmds][3], cmdField[numCmds][4], cmdField[numCmds][5],
                        cmdField[numCmds][6], cmdField[numCmds][7], cmdField[numCmds][8],
                        cmdField[numCmds][9]));
                    cmdLine[numCmds] = lineNo;
                    order[numCmds]   = numCmds;
                    numCmds++;
                end
            end
            $fclose(fd);
        end
    endtask

    // each run of S lines executes in a random order
    task automatic shuffleRuns();
        int first;
        int last;
        int pick;
        int tmp;
        first = 0;
        while (first < numCmds) begin
            if (cmdKind[first] != "S") begin
                first++;
            end else begin
                last = first;
                while (last + 1 < numCmds && cmdKind[last + 1] == "S") begin
                    last++;
                end
                for (int i = last; i > first; i--) begin
                    randState   = nextRandom(randState);
                    pick        = first + int'(randState % (i - first + 1));
                    tmp         = order[i];
                    order[i]    = order[pick];
                    order[pick] = tmp;
                end
                first = last + 1;
            end
        end
    endtask

    task automatic writeTlb(input int n);
        tlbWriteIndex       = cmdField[n][0][3:0];
        tlbWriteEntry       = '0;
        tlbWriteEntry.vpn2  = cmdField[n][1][18:0];
        tlbWriteEntry.pfn0  = cmdField[n][2][19:0];
        tlbWriteEntry.c0    = cmdField[n][3][2:0];
        tlbWriteEntry.d0    = cmdField[n][4][0];
        tlbWriteEntry.v0    = cmdField[n][5][0];
        tlbWriteEntry.pfn1  = cmdField[n][6][19:0];
        tlbWriteEntry.c1    = cmdField[n][7][2:0];
        tlbWriteEntry.d1    = cmdField[n][8][0];
        tlbWriteEntry.v1    = cmdField[n][9][0];
        tlbWriteEntry.valid = 1'b1;
        tlbWrite            = 1'b1;
        @(negedge clk);
        tlbWrite = 1'b0;
    endtask

    // fb is the first fetch field of the command
    task automatic runAccess(input int n, input bit doData, input bit doFetch, input int fb);
        string tag;
        tag = $sformatf("line %0d %c", cmdLine[n], cmdKind[n]);
        if (doData) begin
            dataVpn   = cmdField[n][0][19:0];
            dataRead  = cmdField[n][1][0];
            dataStore = cmdField[n][2][0];
            configK0  = cmdField[n][3][2:0];
        end
        if (doFetch) begin
            fetchVpn = cmdField[n][fb][19:0];
            fetchEn  = 1'b1;
        end
        do begin
            @(negedge clk);
        end while (dataStall || fetchStall);
        if (doData) begin
            checkValue({tag, " dataPfn"}, cmdField[n][4], 32'(dataPfn));
            checkValue({tag, " dataUncached"}, cmdField[n][5], 32'(dataUncached));
            checkValue({tag, " dataExc"}, cmdField[n][6], 32'(dataExc));
        end
        if (doFetch) begin
            checkValue({tag, " fetchPfn"}, cmdField[n][fb + 1], 32'(fetchPfn));
            checkValue({tag, " fetchExc"}, cmdField[n][fb + 2], 32'(fetchExc));
        end
        dataRead  = 1'b0;
        dataStore = 1'b0;
        fetchEn   = 1'b0;
    endtask

    task automatic runCommand(input int n);
        case (cmdKind[n])
            "W":     writeTlb(n);
            "D":     runAccess(n, 1'b1, 1'b0, 0);
            "S":     runAccess(n, 1'b1, 1'b0, 0);
            "F":     runAccess(n, 1'b0, 1'b1, 0);
            "B":     runAccess(n, 1'b1, 1'b1, 7);
            default: abortRun($sformatf("unknown command on line %0d", cmdLine[n]));
        endcase
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        dataVpn       = '0;
        dataRead      = 1'b0;
        dataStore     = 1'b0;
        configK0      = '0;
        fetchVpn      = '0;
        fetchEn       = 1'b0;
        tlbWrite      = 1'b0;
        tlbWriteIndex = '0;
        tlbWriteEntry = '0;
        cycles        = 0;
        cycleLimit    = 0;
        numCmds       = 0;
        randState     = randomSeed;
        readCommands();
        shuffleRuns();
        cycleLimit = 40 * numCmds + 3;   // plus the reset cycles
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < numCmds; i++) begin
            runCommand(order[i]);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- mmuTestdata.txt
# W: index vpn2 pfn0 c0 d0 v0 pfn1 c1 d1 v1 | D,S: vpn read store configK0 pfn uncached exc
# F: vpn pfn exc | B: D columns then F columns | hex, ffffffff = not checked, S runs shuffled
D 80123 1 0 3 00123 0 0
D 80123 1 0 2 00123 1 0
D B1234 0 1 3 11234 1 0
D 9ABCD 1 0 3 1ABCD 0 0
F A7000 07000 0
D 00400 1 0 3 ffffffff ffffffff 2
W 0 00200 12345 3 1 1 23456 2 0 1
D 00400 1 0 3 12345 0 0
D 00401 1 0 3 23456 1 0
D 00401 0 1 3 23456 1 1
D 00800 0 1 3 ffffffff ffffffff 3
W 1 00300 34567 3 1 0 45678 3 1 1
D 00600 1 0 3 34567 0 4
D 00600 0 1 3 34567 0 5
D 00601 0 1 3 45678 0 0
W 1 00300 3abcd 3 1 1 4bcde 2 1 1
D 00601 1 0 3 4bcde 1 0
F 00401 23456 0
F 00a00 ffffffff 6
W 2 01000 0a0a0 3 1 1 0b0b0 0 0 1
W 3 01800 0c0c0 3 0 1 0d0d0 3 1 0
B 02001 1 0 3 0b0b0 1 0 03000 0c0c0 0
B 03001 0 1 3 0d0d0 0 5 02000 0a0a0 0
F 03001 0d0d0 7
W 4 02400 7e3a1 3 1 1 1c94f 5 1 1
W 5 02c00 b2d07 2 0 1 4f1e6 3 0 1
S 04800 1 0 3 7e3a1 0 0
S 04801 0 1 3 1c94f 1 0
S 05800 1 0 3 b2d07 1 0
S 05801 0 1 3 4f1e6 0 1

//--- mmuTop.sv
`timescale 1ns/1ps
`default_nettype none

module mmuTop (
    input  logic                clk,
    input  logic                reset,
    input  mmuPkg::vpn_t        dataVpn,
    input  logic                dataRead,
    input  logic                dataStore,
    input  mmuPkg::cacheAttr_t  configK0,
    input  mmuPkg::vpn_t        fetchVpn,
    input  logic                fetchEn,
    input  logic                tlbWrite,
    input  mmuPkg::tlbIndex_t   tlbWriteIndex,
    input  mmuPkg::tlbEntry_t   tlbWriteEntry,
    output mmuPkg::pfn_t        dataPfn,
    output logic                dataUncached,
    output mmuPkg::excCode_t    dataExc,
    output logic                dataStall,
    output mmuPkg::pfn_t        fetchPfn,
    output mmuPkg::excCode_t    fetchExc,
    output logic                fetchStall
);

    tlbLookupIf dataLookup ();
    tlbLookupIf instLookup ();
    tlbLookupIf tlbPort ();

    // any TLB write may change a buffered entry, so both buffers drop theirs
    dataTlbBuffer dataBuf (
        .clk      (clk),
        .reset    (reset),
        .flush    (tlbWrite),
        .vpn      (dataVpn),
        .read     (dataRead),
        .store    (dataStore),
        .configK0 (configK0),
        .pfn      (dataPfn),
        .uncached (dataUncached),
        .exc      (dataExc),
        .stall    (dataStall),
        .lookup   (dataLookup.requester)
    );

    instTlbBuffer instBuf (
        .clk     (clk),
        .reset   (reset),
        .flush   (tlbWrite),
        .vpn     (fetchVpn),
        .fetchEn (fetchEn),
        .pfn     (fetchPfn),
        .exc     (fetchExc),
        .stall   (fetchStall),
        .lookup  (instLookup.requester)
    );

    tlbArbiter arbiter (
        .clk      (clk),
        .reset    (reset),
        .dataSide (dataLookup.responder),
        .instSide (instLookup.responder),
        .tlbSide  (tlbPort.requester)
    );

    jointTlb tlb (
        .clk        (clk),
        .reset      (reset),
        .write      (tlbWrite),
        .writeIndex (tlbWriteIndex),
        .writeEntry (tlbWriteEntry),
        .port       (tlbPort.responder)
    );

endmodule

`default_nettype wire

//--- project.f
mmuPkg.sv
tlbLookupIf.sv
jointTlb.sv
tlbArbiter.sv
dataTlbBuffer.sv
instTlbBuffer.sv
mmuTop.sv
mmuTb.sv

//--- tlbArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tlbArbiter (
    input  logic           clk,
    input  logic           reset,
    tlbLookupIf.responder  dataSide,
    tlbLookupIf.responder  instSide,
    tlbLookupIf.requester  tlbSide
);
    import mmuPkg::*;

    grant_t grant;
    grant_t grantSel;                  // owner of the lookup port this cycle
    logic   dataAck;
    logic   instAck;

    always_comb begin
        grantSel = grant;
        if ((grant == grantData && !dataSide.req) || (grant == grantInst && !instSide.req)) begin
            grantSel = grantNone;      // owner has dropped req
        end
        if (grantSel == grantNone) begin
            if (dataSide.req) begin
                grantSel = grantData;  // data wins a tie
            end else if (instSide.req) begin
                grantSel = grantInst;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant   <= grantNone;
            dataAck <= 1'b0;
            instAck <= 1'b0;
        end else begin
            grant   <= grantSel;
            dataAck <= tlbSide.ack && (grantSel == grantData);
            instAck <= tlbSide.ack && (grantSel == grantInst);
        end
    end

    assign tlbSide.req  = (grantSel == grantData && dataSide.req) ||
                          (grantSel == grantInst && instSide.req);
    assign tlbSide.vpn2 = (grantSel == grantInst) ? instSide.vpn2 : dataSide.vpn2;

    assign dataSide.ack   = dataAck;
    assign dataSide.found = tlbSide.found && (grantSel == grantData);
    assign dataSide.entry = tlbSide.entry;
    assign instSide.ack   = instAck;
    assign instSide.found = tlbSide.found && (grantSel == grantInst);
    assign instSide.entry = tlbSide.entry;

    // the owner keeps its req up until acked, so the grant cannot move mid-handshake
    assert property (@(posedge clk) disable iff (reset)
        ((grantSel == grantData && !dataAck) |=> dataSide.req) and
        ((grantSel == grantInst && !instAck) |=> instSide.req))
        else $error("granted req withdrawn before its ack");

    assert property (@(posedge clk) disable iff (reset)
        ($rose(dataAck) |-> grantSel == grantData) and
        ($rose(instAck) |-> grantSel == grantInst))
        else $error("ack raised toward a side without the grant");

endmodule

`default_nettype wire

//--- tlbLookupIf.sv
`timescale 1ns/1ps
`default_nettype none

// one refill lookup, four-phase req/ack
interface tlbLookupIf;
    import mmuPkg::*;

    logic      req;
    vpn2_t     vpn2;                   // stable while req is high
    logic      ack;
    logic      found;
    tlbEntry_t entry;                  // valid while ack is high

    modport requester (
        output req,
        output vpn2,
        input  ack,
        input  found,
        input  entry
    );

    modport responder (
        input  req,
        input  vpn2,
        output ack,
        output found,
        output entry
    );

endinterface

`default_nettype wire
